// File: clockTop.f
rtl/clockPkg.sv
rtl/editCmdIf.sv
rtl/keypadDecoder.sv
rtl/timekeeper.sv
rtl/hhmmEditor.sv
rtl/alarmMatcher.sv
rtl/displayDriver.sv
rtl/clockTop.sv
verification/clockTop_props.sv
verification/clockTop_tb.sv

// File: rtl/alarmMatcher.sv
`timescale 1ns/1ns
`default_nettype none

module alarmMatcher (
  input  logic             clk1hz,
  input  logic             reset,
  input  logic             armed,       // switch3
  input  logic             anyPress,
  input  clockPkg::hourT   hours,
  input  clockPkg::minuteT minutes,
  input  clockPkg::hourT   alarmHours,
  input  clockPkg::minuteT alarmMinutes,
  output logic             led
);

  logic match;
  logic ringing;
  logic ringingNext;

  // seconds are not compared, the whole minute matches
  assign match = (hours == alarmHours) && (minutes == alarmMinutes);

  always_comb begin
    ringingNext = ringing;
    if (anyPress) ringingNext = 1'b0; // a press always silences
    else if (armed && match) ringingNext = 1'b1;
  end

  // led follows ringingNext so it is never high once ringing clears
  always_ff @(posedge clk1hz or negedge reset) begin
    if (!reset) begin
      ringing <= 1'b0;
      led     <= 1'b0;
    end else begin
      ringing <= ringingNext;
      if (ringingNext) begin
        led <= !led;
      end else begin
        led <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/clockPkg.sv
`default_nettype none

package clockPkg;

  typedef logic [4:0] hourT;   // 0 to 23
  typedef logic [5:0] minuteT; // 0 to 59, also used for seconds

  localparam hourT HOUR_MAX = 5'd23;
  localparam minuteT MINUTE_MAX = 6'd59;
  localparam hourT ALARM_DEFAULT_HOUR = 5'd8;

  // decoded from switch1/switch2, both high falls back to run
  typedef enum logic [1:0] {
    modeRun      = 2'd0,
    modeSetTime  = 2'd1,
    modeSetAlarm = 2'd2
  } modeT;

  typedef enum logic {
    fieldMinutes = 1'b0,
    fieldHours   = 1'b1
  } fieldT;

  // active-low segments, bit 6 is segment g and bit 0 is segment a
  localparam logic [6:0] SEG_BLANK = 7'b1111111;
  localparam logic [6:0] SEG_TABLE [10] = '{
    7'b1000000, // 0
    7'b1111001, // 1
    7'b0100100, // 2
    7'b0110000, // 3
    7'b0011001, // 4
    7'b0010010, // 5
    7'b0000010, // 6
    7'b1111000, // 7
    7'b0000000, // 8
    7'b0010000  // 9
  };

endpackage

`default_nettype wire

// File: rtl/clockTop.sv
`timescale 1ns/1ns
`default_nettype none

module clockTop (
  input  logic       clk1hz,
  input  logic       reset,       // active low
  input  logic       switch1,
  input  logic       switch2,
  input  logic       switch3,     // alarm enable
  input  logic       incrementar,
  input  logic       decrementar,
  input  logic       cambiar,
  input  logic       establecer,
  output logic [6:0] displayH2,
  output logic [6:0] displayH1,
  output logic [6:0] displayM2,
  output logic [6:0] displayM1,
  output logic       led
);

  clockPkg::modeT   mode;
  logic             anyPress;
  logic             commit;
  clockPkg::hourT   timeHours;
  clockPkg::minuteT timeMinutes;
  clockPkg::hourT   editHours;
  clockPkg::minuteT editMinutes;
  clockPkg::hourT   alarmHours;
  clockPkg::minuteT alarmMinutes;

  editCmdIf timeCmd ();
  editCmdIf alarmCmd ();

  keypadDecoder keypad (
    .clk1hz      (clk1hz),
    .reset       (reset),
    .switch1     (switch1),
    .switch2     (switch2),
    .incrementar (incrementar),
    .decrementar (decrementar),
    .cambiar     (cambiar),
    .establecer  (establecer),
    .mode        (mode),
    .anyPress    (anyPress),
    .commit      (commit),
    .timeCmd     (timeCmd.keypad),
    .alarmCmd    (alarmCmd.keypad)
  );

  // seconds are kept inside the timekeeper and shown nowhere
  timekeeper timeKeeper (
    .clk1hz      (clk1hz),
    .reset       (reset),
    .commit      (commit),
    .loadHours   (editHours),
    .loadMinutes (editMinutes),
    .hours       (timeHours),
    .minutes     (timeMinutes),
    .seconds     ()
  );

  // set-time editor starts from the live time
  hhmmEditor #(.resetHour(5'd0)) timeEditor (
    .clk1hz      (clk1hz),
    .reset       (reset),
    .cmd         (timeCmd.editor),
    .seedEnable  (1'b1),
    .seedHours   (timeHours),
    .seedMinutes (timeMinutes),
    .hours       (editHours),
    .minutes     (editMinutes)
  );

  // alarm editor keeps its own value across entries
  hhmmEditor #(.resetHour(clockPkg::ALARM_DEFAULT_HOUR)) alarmEditor (
    .clk1hz      (clk1hz),
    .reset       (reset),
    .cmd         (alarmCmd.editor),
    .seedEnable  (1'b0),
    .seedHours   (timeHours),
    .seedMinutes (timeMinutes),
    .hours       (alarmHours),
    .minutes     (alarmMinutes)
  );

  alarmMatcher matcher (
    .clk1hz       (clk1hz),
    .reset        (reset),
    .armed        (switch3),
    .anyPress     (anyPress),
    .hours        (timeHours),
    .minutes      (timeMinutes),
    .alarmHours   (alarmHours),
    .alarmMinutes (alarmMinutes),
    .led          (led)
  );

  displayDriver display (
    .mode         (mode),
    .timeHours    (timeHours),
    .timeMinutes  (timeMinutes),
    .editHours    (editHours),
    .editMinutes  (editMinutes),
    .alarmHours   (alarmHours),
    .alarmMinutes (alarmMinutes),
    .displayH2    (displayH2),
    .displayH1    (displayH1),
    .displayM2    (displayM2),
    .displayM1    (displayM1)
  );

endmodule

`default_nettype wire

// File: rtl/displayDriver.sv
`timescale 1ns/1ns
`default_nettype none

module displayDriver (
  input  clockPkg::modeT   mode,
  input  clockPkg::hourT   timeHours,
  input  clockPkg::minuteT timeMinutes,
  input  clockPkg::hourT   editHours,
  input  clockPkg::minuteT editMinutes,
  input  clockPkg::hourT   alarmHours,
  input  clockPkg::minuteT alarmMinutes,
  output logic [6:0]       displayH2, // hours tens
  output logic [6:0]       displayH1, // hours units
  output logic [6:0]       displayM2, // minutes tens
  output logic [6:0]       displayM1  // minutes units
);

  clockPkg::hourT   showHours;
  clockPkg::minuteT showMinutes;
  logic [3:0]       hoursTens, hoursUnits;
  logic [3:0]       minutesTens, minutesUnits;

  // digit to active-low segments
  function automatic logic [6:0] segOf(input logic [3:0] digit);
    if (digit > 4'd9) begin
      return clockPkg::SEG_BLANK;
    end
    return clockPkg::SEG_TABLE[digit];
  endfunction

  always_comb begin
    case (mode)
      clockPkg::modeSetTime: begin
        showHours   = editHours;
        showMinutes = editMinutes;
      end
      clockPkg::modeSetAlarm: begin
        showHours   = alarmHours;
        showMinutes = alarmMinutes;
      end
      default: begin
        showHours   = timeHours;
        showMinutes = timeMinutes;
      end
    endcase
  end

  // values stay below 60 so every quotient fits a digit
  assign hoursTens    = 4'(showHours / 5'd10);
  assign hoursUnits   = 4'(showHours % 5'd10);
  assign minutesTens  = 4'(showMinutes / 6'd10);
  assign minutesUnits = 4'(showMinutes % 6'd10);

  assign displayH2 = segOf(hoursTens);
  assign displayH1 = segOf(hoursUnits);
  assign displayM2 = segOf(minutesTens);
  assign displayM1 = segOf(minutesUnits);

endmodule

`default_nettype wire

// File: rtl/editCmdIf.sv
`timescale 1ns/1ns
`default_nettype none

// decoded edit commands, one set per editor
interface editCmdIf;
  logic enable;      // editor's mode is selected
  logic stepUp;      // move selected field +1
  logic stepDown;    // move selected field -1
  logic toggleField; // swap between minutes and hours

  modport keypad (
    output enable, stepUp, stepDown, toggleField
  );

  modport editor (
    input enable, stepUp, stepDown, toggleField
  );
endinterface

`default_nettype wire

// File: rtl/hhmmEditor.sv
`timescale 1ns/1ns
`default_nettype none

module hhmmEditor #(
  parameter clockPkg::hourT resetHour = 5'd0
) (
  input  logic             clk1hz,
  input  logic             reset,
  editCmdIf.editor         cmd,
  input  logic             seedEnable,  // copy the seed on mode entry
  input  clockPkg::hourT   seedHours,
  input  clockPkg::minuteT seedMinutes,
  output clockPkg::hourT   hours,
  output clockPkg::minuteT minutes
);

  clockPkg::fieldT  field;
  clockPkg::fieldT  nextField;
  clockPkg::hourT   nextHours;
  clockPkg::minuteT nextMinutes;
  logic             active; // enable was already high last cycle

  // toggle takes effect before the step in the same cycle
  always_comb begin
    nextField   = field;
    nextHours   = hours;
    nextMinutes = minutes;
    if (cmd.toggleField) begin
      nextField = (field == clockPkg::fieldHours) ? clockPkg::fieldMinutes
                                                  : clockPkg::fieldHours;
    end
    if (nextField == clockPkg::fieldHours) begin
      if (cmd.stepUp) begin
        nextHours = (hours == clockPkg::HOUR_MAX) ? 5'd0 : hours + 5'd1;
      end else if (cmd.stepDown) begin
        nextHours = (hours == 5'd0) ? clockPkg::HOUR_MAX : hours - 5'd1;
      end
    end else begin
      if (cmd.stepUp) begin
        nextMinutes = (minutes == clockPkg::MINUTE_MAX) ? 6'd0 : minutes + 6'd1;
      end else if (cmd.stepDown) begin
        nextMinutes = (minutes == 6'd0) ? clockPkg::MINUTE_MAX : minutes - 6'd1;
      end
    end
  end

  always_ff @(posedge clk1hz or negedge reset) begin
    if (!reset) begin
      hours   <= resetHour;
      minutes <= '0;
      field   <= clockPkg::fieldMinutes;
      active  <= 1'b0;
    end else if (!cmd.enable) begin
      active <= 1'b0;
    end else if (!active) begin
      active <= 1'b1; // entry cycle, commands are ignored
      if (seedEnable) begin
        hours   <= seedHours;
        minutes <= seedMinutes;
      end
    end else begin
      field   <= nextField;
      hours   <= nextHours;
      minutes <= nextMinutes;
    end
  end

endmodule

`default_nettype wire

// File: rtl/keypadDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module keypadDecoder (
  input  logic              clk1hz,
  input  logic              reset,
  input  logic              switch1,
  input  logic              switch2,
  input  logic              incrementar, // buttons are active low
  input  logic              decrementar,
  input  logic              cambiar,
  input  logic              establecer,
  output clockPkg::modeT    mode,
  output logic              anyPress,
  output logic              commit,
  editCmdIf.keypad          timeCmd,
  editCmdIf.keypad          alarmCmd
);

  logic sw1Q, sw2Q;
  logic incQ, decQ, camQ, estQ;
  logic upLevel, downLevel, toggleLevel;

  // one stage of registering, buttons idle high
  always_ff @(posedge clk1hz or negedge reset) begin
    if (!reset) begin
      sw1Q <= 1'b0;
      sw2Q <= 1'b0;
      incQ <= 1'b1;
      decQ <= 1'b1;
      camQ <= 1'b1;
      estQ <= 1'b1;
    end else begin
      sw1Q <= switch1;
      sw2Q <= switch2;
      incQ <= incrementar;
      decQ <= decrementar;
      camQ <= cambiar;
      estQ <= establecer;
    end
  end

  always_comb begin
    if (sw1Q && !sw2Q) mode = clockPkg::modeSetTime;
    else if (!sw1Q && sw2Q) mode = clockPkg::modeSetAlarm;
    else mode = clockPkg::modeRun; // includes both switches high
  end

  // both step buttons down together means no step
  assign upLevel     = !incQ && decQ;
  assign downLevel   = !decQ && incQ;
  assign toggleLevel = !camQ;

  assign anyPress = !incQ || !decQ || !camQ || !estQ;
  assign commit   = (mode == clockPkg::modeSetTime) && !estQ;

  assign timeCmd.enable      = (mode == clockPkg::modeSetTime);
  assign timeCmd.stepUp      = timeCmd.enable && upLevel;
  assign timeCmd.stepDown    = timeCmd.enable && downLevel;
  assign timeCmd.toggleField = timeCmd.enable && toggleLevel;

  assign alarmCmd.enable      = (mode == clockPkg::modeSetAlarm);
  assign alarmCmd.stepUp      = alarmCmd.enable && upLevel;
  assign alarmCmd.stepDown    = alarmCmd.enable && downLevel;
  assign alarmCmd.toggleField = alarmCmd.enable && toggleLevel;

endmodule

`default_nettype wire

// File: rtl/timekeeper.sv
`timescale 1ns/1ns
`default_nettype none

module timekeeper (
  input  logic             clk1hz,
  input  logic             reset,
  input  logic             commit,      // load edited value this edge
  input  clockPkg::hourT   loadHours,
  input  clockPkg::minuteT loadMinutes,
  output clockPkg::hourT   hours,
  output clockPkg::minuteT minutes,
  output clockPkg::minuteT seconds
);

  logic secondWrap;
  logic minuteWrap;

  assign secondWrap = (seconds == clockPkg::MINUTE_MAX);
  assign minuteWrap = (minutes == clockPkg::MINUTE_MAX);

  // seconds -> minutes -> hours cascade
  always_ff @(posedge clk1hz or negedge reset) begin
    if (!reset) begin
      hours   <= '0;
      minutes <= '0;
      seconds <= '0;
    end else if (commit) begin
      hours   <= loadHours;
      minutes <= loadMinutes;
      seconds <= '0; // restart the minute from the edit
    end else if (secondWrap) begin
      seconds <= '0;
      if (minuteWrap) begin
        minutes <= '0;
        if (hours == clockPkg::HOUR_MAX) begin
          hours <= '0;
        end else begin
          hours <= hours + 5'd1;
        end
      end else begin
        minutes <= minutes + 6'd1;
      end
    end else begin
      seconds <= seconds + 6'd1;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run with Verilator, pass is decided from sim.log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f clockTop.f --top-module clockTop_tb -o clockTop_sim &&
{ ./obj_dir/clockTop_sim +verilator+error+limit+100 > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -q "TESTBENCH PASSED" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: verification/clockTop_props.sv
`timescale 1ns/1ns
`default_nettype none

module clockTopProps (
  input logic           clk1hz,
  input logic           reset,
  input logic [6:0]     displayH2,
  input logic [6:0]     displayH1,
  input logic [6:0]     displayM2,
  input logic [6:0]     displayM1,
  input logic           led,
  input logic           anyPress,
  input clockPkg::modeT mode
);

  int failCount = 0; // read by the testbench
  int shownMinutes;

  // segment pattern back to its digit, -1 for anything else
  function automatic int digitOf(input logic [6:0] seg);
    for (int i = 0; i < 10; i++) begin
      if (seg == clockPkg::SEG_TABLE[i]) return i;
    end
    return -1;
  endfunction

  assign shownMinutes = digitOf(displayM2) * 10 + digitOf(displayM1);

  validDigits: assert property (@(posedge clk1hz) disable iff (!reset)
    digitOf(displayH2) >= 0 && digitOf(displayH1) >= 0 &&
    digitOf(displayM2) >= 0 && digitOf(displayM1) >= 0)
    else begin
      $error("display output is not a digit pattern");
      failCount++;
    end

  // while ringing with no press the led comes back high two edges later
  ledToggles: assert property (@(posedge clk1hz) disable iff (!reset)
    (led && !anyPress) ##1 !anyPress |=> led)
    else begin
      $error("led stopped toggling while ringing");
      failCount++;
    end

  pressSilences: assert property (@(posedge clk1hz) disable iff (!reset)
    anyPress |=> !led)
    else begin
      $error("led high after a button press");
      failCount++;
    end

  // run mode minutes only hold or advance by one
  runMinuteStep: assert property (@(posedge clk1hz) disable iff (!reset)
    (mode == clockPkg::modeRun && $past(mode) == clockPkg::modeRun) |->
      (shownMinutes == $past(shownMinutes) ||
       shownMinutes == ($past(shownMinutes) + 1) % 60))
    else begin
      $error("shown minutes jumped in run mode");
      failCount++;
    end

endmodule

bind clockTop clockTopProps props (
  .clk1hz    (clk1hz),
  .reset     (reset),
  .displayH2 (displayH2),
  .displayH1 (displayH1),
  .displayM2 (displayM2),
  .displayM1 (displayM1),
  .led       (led),
  .anyPress  (anyPress),
  .mode      (mode)
);

`default_nettype wire

// File: verification/clockTop_tb.sv
`timescale 1ns/1ns
`default_nettype none

module clockTop_tb;

  localparam int TIMEOUT_CYCLES = 600; // about 350 cycles of tests plus margin
  localparam int BTN_INC = 0;
  localparam int BTN_DEC = 1;
  localparam int BTN_CAM = 2;

  logic       clk1hz, reset, switch1, switch2, switch3;
  logic       incrementar, decrementar, cambiar, establecer;
  logic [6:0] displayH2, displayH1, displayM2, displayM1;
  logic       led;
  int         cycleCount;
  int         modelHours, modelMinutes, steps, waitCycles;
  bit         editHoursField; // model of the selected field

  clockTop i_clockTop (.*);

  always #2 clk1hz = !clk1hz;

  always @(posedge clk1hz) begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  always @(negedge clk1hz) begin
    if (i_clockTop.props.failCount != 0) begin
      $display("A bound assertion on the DUT failed");
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  function automatic int digitOf(input logic [6:0] seg);
    for (int i = 0; i < 10; i++) begin
      if (seg == clockPkg::SEG_TABLE[i]) return i;
    end
    return -1;
  endfunction

  function automatic int shownHours();
    return digitOf(displayH2) * 10 + digitOf(displayH1);
  endfunction

  function automatic int shownMinutes();
    return digitOf(displayM2) * 10 + digitOf(displayM1);
  endfunction

  task automatic checkValue(input string name, input int got, input int expected);
    assert (got == expected) else begin
      $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, expected);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic compareDisplay(input int hours, input int minutes);
    checkValue("shownHours", shownHours(), hours);
    checkValue("shownMinutes", shownMinutes(), minutes);
  endtask

  // one clock low, result visible two edges after the press
  task automatic pressAndCheck(input int which);
    @(posedge clk1hz);
    case (which)
      BTN_INC: incrementar <= 1'b0;
      BTN_DEC: decrementar <= 1'b0;
      default: cambiar <= 1'b0;
    endcase
    @(posedge clk1hz);
    incrementar <= 1'b1;
    decrementar <= 1'b1;
    cambiar     <= 1'b1;
    @(posedge clk1hz);
    @(negedge clk1hz);
    if (which == BTN_CAM) editHoursField = !editHoursField;
    else if (editHoursField) modelHours = (modelHours + (which == BTN_INC ? 1 : 23)) % 24;
    else modelMinutes = (modelMinutes + (which == BTN_INC ? 1 : 59)) % 60;
    compareDisplay(modelHours, modelMinutes);
  endtask

  initial begin
    clk1hz = 1'b0;
    reset = 1'b0;
    switch1 = 1'b0;
    switch2 = 1'b0;
    switch3 = 1'b0;
    incrementar = 1'b1;
    decrementar = 1'b1;
    cambiar = 1'b1;
    establecer = 1'b1;
    cycleCount = 0;
    void'($urandom(32'hcaa3));
    repeat (5) @(posedge clk1hz);
    reset <= 1'b1;
    @(negedge clk1hz);
    compareDisplay(0, 0);
    checkValue("led", led, 0);

    // alarm editor from 08:00 down to 00:00
    @(posedge clk1hz);
    switch2 <= 1'b1;
    repeat (3) @(posedge clk1hz);
    @(negedge clk1hz);
    modelHours = 8;
    modelMinutes = 0;
    editHoursField = 1'b0;
    compareDisplay(8, 0);
    pressAndCheck(BTN_CAM);
    repeat (8) pressAndCheck(BTN_DEC);

    // let the live time pass its first minute before it is copied
    repeat (40) @(posedge clk1hz);

    // set-time editor starts from the copied live time
    @(posedge clk1hz);
    switch2 <= 1'b0;
    switch1 <= 1'b1;
    repeat (3) @(posedge clk1hz);
    @(negedge clk1hz);
    modelHours = 0;
    modelMinutes = 1; // live time is a little past 00:01 at the copy
    editHoursField = 1'b0;
    compareDisplay(modelHours, modelMinutes);
    steps = $urandom_range(30, 1);
    repeat (steps) pressAndCheck(BTN_INC);
    pressAndCheck(BTN_CAM);
    while (modelHours != 23) pressAndCheck(BTN_DEC);
    pressAndCheck(BTN_CAM);
    while (modelMinutes != 59) pressAndCheck(BTN_DEC);

    // commit 23:59, back to run mode with the alarm armed
    @(posedge clk1hz);
    establecer <= 1'b0;
    @(posedge clk1hz);
    establecer <= 1'b1;
    switch1 <= 1'b0;
    switch3 <= 1'b1;
    @(posedge clk1hz);
    @(negedge clk1hz);
    compareDisplay(23, 59);
    waitCycles = 0;
    while (shownMinutes() != 0) begin
      @(negedge clk1hz);
      waitCycles++;
    end
    checkValue("minuteWrapCycles", waitCycles, 60);
    compareDisplay(0, 0);

    // alarm at 00:00 rings on the next edge
    @(negedge clk1hz);
    checkValue("led", led, 1);

    // a press and switch3 low silence it
    @(posedge clk1hz);
    cambiar <= 1'b0;
    switch3 <= 1'b0;
    @(posedge clk1hz);
    cambiar <= 1'b1;
    @(posedge clk1hz);
    @(negedge clk1hz);
    checkValue("led", led, 0);
    repeat (10) begin
      @(negedge clk1hz);
      checkValue("led", led, 0);
    end

    if (i_clockTop.props.failCount == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire
